// File: sources.f
rtl/link_cfg_pkg.sv
rtl/link_types_pkg.sv
rtl/credit_sender.sv
rtl/rx_credit_fifo.sv
rtl/credit_return.sv
rtl/credit_link_top.sv
tests/credit_link_properties.sv
tests/credit_link_tb.sv

// File: Makefile
# Verilator build and run of the credit channel testbench

VERILATOR ?= verilator
TOP       ?= credit_link_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
# keep running past assertion errors so the testbench prints its summary
SIMARGS   ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(SIMARGS) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/credit_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

module credit_link_tb;

  // nominal length of each phase in cycles
  // a drain runs until idle and usually settles well inside DRAIN_LEN
  localparam int SEED           = 27;
  localparam int RESET_LEN      = 2;
  localparam int BLOCK_LEN      = 12;
  localparam int DRAIN_LEN      = 24;
  localparam int STREAM_LEN     = 400;
  localparam int STALL_LEN      = 40;
  localparam int RUN_LEN        = RESET_LEN + 2 * BLOCK_LEN + 3 * DRAIN_LEN + STREAM_LEN
                                  + STALL_LEN;
  localparam int TIMEOUT_CYCLES = 2 * RUN_LEN;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        src_valid_i;
  link_types_pkg::data_beat_t  src_beat_i;
  logic                        src_ready_o;
  logic                        sink_ready_i;
  logic                        sink_valid_o;
  link_types_pkg::data_beat_t  sink_beat_o;
  logic                        cred_stall_i;
  logic                        cred_valid_o;
  link_types_pkg::credit_msg_t cred_msg_o;

  // beats accepted by the DUT and not yet seen at the sink, oldest first
  link_types_pkg::data_beat_t ref_q[$];
  string cur_test;
  int cycle_cnt = 0;
  int err_cnt = 0;
  int err_base = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int accepted_cnt = 0;
  int sink_cnt = 0;
  int returned_cnt = 0;

  credit_link_top i_credit_link_top (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .src_valid_i  (src_valid_i),
    .src_beat_i   (src_beat_i),
    .src_ready_o  (src_ready_o),
    .sink_ready_i (sink_ready_i),
    .sink_valid_o (sink_valid_o),
    .sink_beat_o  (sink_beat_o),
    .cred_stall_i (cred_stall_i),
    .cred_valid_o (cred_valid_o),
    .cred_msg_o   (cred_msg_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // the whole run must fit in twice its nominal length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // testbench errors plus failures of the bound assertions
  function automatic int total_errors();
    return err_cnt + i_credit_link_top.i_credit_link_properties.fail_cnt;
  endfunction

  function automatic void start_test(input string name);
    cur_test = name;
    err_base = total_errors();
  endfunction

  function automatic void finish_test();
    tests_run++;
    if (total_errors() == err_base) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, total_errors() - err_base);
    end
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("CHECK FAILED %s %s expected %0d actual %0d", cur_test, what, expected, actual);
      err_cnt++;
    end
  endtask

  // drive one cycle on the falling edge and then observe the settled handshakes
  // that the next rising edge will complete
  task automatic step_cycle(input logic valid, input logic sink_rdy, input logic stall);
    link_types_pkg::data_beat_t exp_beat;
    @(negedge clk_i);
    src_valid_i        = valid;
    src_beat_i.payload = (link_cfg_pkg::DATA_W)'($urandom);
    sink_ready_i       = sink_rdy;
    cred_stall_i       = stall;
    #1;
    if (src_valid_i && src_ready_o) begin
      ref_q.push_back(src_beat_i);
      accepted_cnt++;
    end
    if (sink_valid_o && sink_ready_i) begin
      sink_cnt++;
      assert (ref_q.size() > 0) else begin
        $display("test %s: sink took a beat while none was outstanding", cur_test);
        err_cnt++;
      end
      if (ref_q.size() > 0) begin
        exp_beat = ref_q.pop_front();
        assert (sink_beat_o == exp_beat) else begin
          $display("CHECK FAILED %s sink beat expected %h actual %h", cur_test,
                   exp_beat.payload, sink_beat_o.payload);
          err_cnt++;
        end
      end
    end
    if (cred_valid_o && !cred_stall_i) begin
      returned_cnt += int'(cred_msg_o.count);
    end
  endtask

  // with the sink blocked and the source always valid exactly the full credit count gets in
  task automatic fill_blocked();
    int base;
    base = accepted_cnt;
    repeat (BLOCK_LEN) step_cycle(1'b1, 1'b0, 1'b0);
    check_value("accepted beats", link_cfg_pkg::NUM_CREDITS, accepted_cnt - base);
    check_value("src_ready_o", 0, int'(src_ready_o));
  endtask

  // the source idles and the sink drains with no stall until four quiet cycles in a row
  task automatic drain_until_idle();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      step_cycle(1'b0, 1'b1, 1'b0);
      quiet = (!sink_valid_o && !cred_valid_o) ? quiet + 1 : 0;
    end
    // every popped entry has come back as a credit
    check_value("queued beats", 0, ref_q.size());
    check_value("returned credits", sink_cnt, returned_cnt);
    check_value("src_ready_o", 1, int'(src_ready_o));
  endtask

  ////////////////////////////////////////////////////////////
  // phases
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n_i      = 1'b0;
    src_valid_i  = 1'b0;
    src_beat_i   = '0;
    sink_ready_i = 1'b0;
    cred_stall_i = 1'b0;

    start_test("reset");
    repeat (RESET_LEN) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_value("src_ready_o", 1, int'(src_ready_o));
    check_value("sink_valid_o", 0, int'(sink_valid_o));
    check_value("cred_valid_o", 0, int'(cred_valid_o));
    finish_test();

    start_test("sink_blocked");
    fill_blocked();
    finish_test();

    start_test("drain");
    drain_until_idle();
    finish_test();

    // valid, ready and stall are random and the lane stalls about one cycle in four
    start_test("random_stream");
    repeat (STREAM_LEN) begin
      step_cycle(($urandom % 4) != 0, ($urandom % 3) != 0, ($urandom % 4) == 0);
    end
    drain_until_idle();
    finish_test();

    // a long stall on the return lane is released before the whole buffer is refilled
    start_test("return_stall");
    repeat (STALL_LEN) step_cycle(($urandom % 2) == 1, 1'b1, 1'b1);
    drain_until_idle();
    fill_blocked();
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/credit_link_properties.sv
`timescale 1ns/100ps
`default_nettype none

// port-level rules of the credit channel, bound into credit_link_top
module credit_link_properties (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        src_valid_i,
  input logic                        src_ready_o,
  input logic                        cred_stall_i,
  input logic                        cred_valid_o,
  input link_types_pkg::credit_msg_t cred_msg_o
);

  // beats accepted whose credit has not come back yet
  int outstanding;
  // number of failed assertions that the testbench folds into its error total
  int fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(src_valid_i && src_ready_o)
                     - ((cred_valid_o && !cred_stall_i) ? int'(cred_msg_o.count) : 0);
    end
  end

  reset_idle_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> src_ready_o && !cred_valid_o)
    else begin
      fail_cnt++;
      $error("outputs not idle after reset");
    end

  // the sender never spends more than the buffer depth
  // ready drops exactly when the last credit is spent
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding >= 0 && outstanding <= link_cfg_pkg::NUM_CREDITS
    && src_ready_o == (outstanding != link_cfg_pkg::NUM_CREDITS))
    else begin
      fail_cnt++;
      $error("outstanding beats %0d out of credit range", outstanding);
    end

  stable_offer_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cred_valid_o && cred_stall_i |=> cred_valid_o && $stable(cred_msg_o.count))
    else begin
      fail_cnt++;
      $error("stalled credit message changed");
    end

  count_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cred_valid_o |-> cred_msg_o.count != '0
    && int'(cred_msg_o.count) <= link_cfg_pkg::NUM_CREDITS)
    else begin
      fail_cnt++;
      $error("credit count %0d out of range", cred_msg_o.count);
    end

endmodule

bind credit_link_top credit_link_properties i_credit_link_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .src_valid_i  (src_valid_i),
  .src_ready_o  (src_ready_o),
  .cred_stall_i (cred_stall_i),
  .cred_valid_o (cred_valid_o),
  .cred_msg_o   (cred_msg_o)
);

`default_nettype wire

// File: rtl/credit_link_top.sv
`timescale 1ns/100ps
`default_nettype none

// one-way credit controlled channel
// the credit message leaves at the ports and is looped back to the sender on transfer
module credit_link_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // source side
  input  logic                        src_valid_i,
  input  link_types_pkg::data_beat_t  src_beat_i,
  output logic                        src_ready_o,
  // sink side
  input  logic                        sink_ready_i,
  output logic                        sink_valid_o,
  output link_types_pkg::data_beat_t  sink_beat_o,
  // credit return lane
  input  logic                        cred_stall_i,
  output logic                        cred_valid_o,
  output link_types_pkg::credit_msg_t cred_msg_o
);

  // sender to buffer
  logic                       push;
  link_types_pkg::data_beat_t push_beat;

  // buffer to credit return
  logic pop;
  logic empty;

  // a message counts as delivered when it is valid and not stalled
  logic cred_strobe;

  assign cred_strobe = cred_valid_o & ~cred_stall_i;

  credit_sender i_credit_sender (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .src_valid_i   (src_valid_i),
    .src_beat_i    (src_beat_i),
    .src_ready_o   (src_ready_o),
    .cred_strobe_i (cred_strobe),
    .cred_msg_i    (cred_msg_o),
    .push_o        (push),
    .push_beat_o   (push_beat)
  );

  rx_credit_fifo i_rx_credit_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_beat_i  (push_beat),
    .sink_ready_i (sink_ready_i),
    .sink_valid_o (sink_valid_o),
    .sink_beat_o  (sink_beat_o),
    .pop_o        (pop),
    .empty_o      (empty)
  );

  credit_return i_credit_return (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pop_i        (pop),
    .empty_i      (empty),
    .cred_stall_i (cred_stall_i),
    .cred_valid_o (cred_valid_o),
    .cred_msg_o   (cred_msg_o)
  );

endmodule

`default_nettype wire

// File: rtl/credit_return.sv
`timescale 1ns/100ps
`default_nettype none

// sink side credit return
// counts the entries drained from the receive buffer and hands them back as a credit
// message once enough have gathered or the buffer has run dry
module credit_return (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // status from the receive buffer
  input  logic                        pop_i,
  input  logic                        empty_i,
  // return lane
  input  logic                        cred_stall_i,
  output logic                        cred_valid_o,
  output link_types_pkg::credit_msg_t cred_msg_o
);

  link_types_pkg::ret_state_e state_q;
  link_types_pkg::ret_state_e state_d;

  // visible counter, this is the count that goes out in the message
  logic [link_cfg_pkg::CREDIT_W-1:0] freed_q;
  logic [link_cfg_pkg::CREDIT_W-1:0] freed_d;

  // shadow counter that collects pops while an offer is pending
  logic [link_cfg_pkg::CREDIT_W-1:0] shadow_q;
  logic [link_cfg_pkg::CREDIT_W-1:0] shadow_d;

  // a single pop widened to counter size
  logic [link_cfg_pkg::CREDIT_W-1:0] pop_cnt;

  logic offer_cond;
  logic msg_taken;

  assign pop_cnt = {{(link_cfg_pkg::CREDIT_W-1){1'b0}}, pop_i};

  ////////////////////////////////////////////////////////////
  // offer decision
  ////////////////////////////////////////////////////////////

  // send when the threshold is reached, or when the sink has drained everything and
  // credits are still owed, since no further pop would come to push the count higher
  assign offer_cond = (freed_q >= (link_cfg_pkg::CREDIT_W)'(link_cfg_pkg::FORCE_SEND_THRESH))
                   || (empty_i && (freed_q != '0));

  // the message is valid for the whole RET_OFFER state
  assign cred_valid_o     = (state_q == link_types_pkg::RET_OFFER);
  assign cred_msg_o.count = freed_q;

  // the return lane takes the message on the first cycle without stall
  assign msg_taken = cred_valid_o & ~cred_stall_i;

  ////////////////////////////////////////////////////////////
  // state machine and counters
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    freed_d  = freed_q;
    shadow_d = shadow_q;
    unique case (state_q)
      link_types_pkg::RET_COUNT: begin
        // a pop in the deciding cycle still joins the message about to be offered
        freed_d = freed_q + pop_cnt;
        if (offer_cond) begin
          state_d = link_types_pkg::RET_OFFER;
        end
      end
      link_types_pkg::RET_OFFER: begin
        if (msg_taken) begin
          // the sent count is dropped, whatever the shadow gathered becomes visible
          freed_d  = shadow_q + pop_cnt;
          shadow_d = '0;
          state_d  = link_types_pkg::RET_COUNT;
        end else begin
          // keep the offered count frozen and park new pops in the shadow
          shadow_d = shadow_q + pop_cnt;
        end
      end
      default: begin
        state_d = link_types_pkg::RET_COUNT;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= link_types_pkg::RET_COUNT;
      freed_q  <= '0;
      shadow_q <= '0;
    end else begin
      state_q  <= state_d;
      freed_q  <= freed_d;
      shadow_q <= shadow_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rx_credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// receive buffer at the sink side
// its depth equals the credit count, so a push is never refused and no full flag exists
module rx_credit_fifo (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // write side, driven by the credit sender
  input  logic                       push_i,
  input  link_types_pkg::data_beat_t push_beat_i,
  // sink handshake
  input  logic                       sink_ready_i,
  output logic                       sink_valid_o,
  output link_types_pkg::data_beat_t sink_beat_o,
  // status toward the credit return block
  output logic                       pop_o,
  output logic                       empty_o
);

  // storage for the beats in flight
  link_types_pkg::data_beat_t mem_q [link_cfg_pkg::NUM_CREDITS];

  // circular pointers and fill level
  logic [link_cfg_pkg::PTR_W-1:0]    wr_ptr_q;
  logic [link_cfg_pkg::PTR_W-1:0]    rd_ptr_q;
  logic [link_cfg_pkg::CREDIT_W-1:0] count_q;

  // advance a pointer and wrap after the last entry
  function automatic logic [link_cfg_pkg::PTR_W-1:0] ptr_incr(
    input logic [link_cfg_pkg::PTR_W-1:0] ptr
  );
    if (ptr == (link_cfg_pkg::PTR_W)'(link_cfg_pkg::NUM_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // sink side
  ////////////////////////////////////////////////////////////

  assign empty_o      = (count_q == '0);
  assign sink_valid_o = ~empty_o;

  // head entry is read straight from storage, a new beat needs one edge to show up
  assign sink_beat_o  = mem_q[rd_ptr_q];

  // an entry leaves when the sink takes the valid head
  assign pop_o        = sink_valid_o & sink_ready_i;

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop_o) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      // fill level moves only when exactly one of push and pop happens
      unique case ({push_i, pop_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/credit_sender.sv
`timescale 1ns/100ps
`default_nettype none

// source side of the credit channel
// a beat is only accepted while the available-credit counter is nonzero, so the
// receive buffer can never be written beyond its depth
module credit_sender (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // source handshake
  input  logic                        src_valid_i,
  input  link_types_pkg::data_beat_t  src_beat_i,
  output logic                        src_ready_o,
  // credit message transferred back from the sink side
  input  logic                        cred_strobe_i,
  input  link_types_pkg::credit_msg_t cred_msg_i,
  // write port toward the receive buffer
  output logic                        push_o,
  output link_types_pkg::data_beat_t  push_beat_o
);

  // credits the sender may still spend
  logic [link_cfg_pkg::CREDIT_W-1:0] credits_q;
  logic [link_cfg_pkg::CREDIT_W-1:0] credits_d;

  // amounts added and removed in the current cycle
  logic [link_cfg_pkg::CREDIT_W-1:0] credits_inc;
  logic [link_cfg_pkg::CREDIT_W-1:0] credits_dec;

  ////////////////////////////////////////////////////////////
  // handshake toward source and buffer
  ////////////////////////////////////////////////////////////

  // one credit left is enough to take one more beat
  assign src_ready_o = (credits_q != '0);

  // every accepted beat is written into the buffer on the same edge
  assign push_o      = src_valid_i & src_ready_o;
  assign push_beat_o = src_beat_i;

  ////////////////////////////////////////////////////////////
  // available-credit counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    // returned credits arrive as a whole message count
    credits_inc = '0;
    if (cred_strobe_i) begin
      credits_inc = cred_msg_i.count;
    end
    // an accepted beat always costs exactly one credit
    credits_dec = {{(link_cfg_pkg::CREDIT_W-1){1'b0}}, push_o};
  end

  // take and return can fall on the same edge, both are applied together
  // the sum never exceeds NUM_CREDITS since only spent credits come back
  assign credits_d = credits_q + credits_inc - credits_dec;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // the sink buffer starts empty, so every entry is free
      credits_q <= (link_cfg_pkg::CREDIT_W)'(link_cfg_pkg::NUM_CREDITS);
    end else begin
      credits_q <= credits_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/link_types_pkg.sv
`default_nettype none

// types that cross module boundaries inside the credit channel
package link_types_pkg;

  ////////////////////////////////////////////////////////////
  // payload and credit message
  ////////////////////////////////////////////////////////////

  // one beat of user data, carried unchanged from source to sink
  typedef struct packed {
    logic [link_cfg_pkg::DATA_W-1:0] payload;
  } data_beat_t;

  // credit message sent back over the return lane
  // count holds how many buffer entries were freed since the last message
  typedef struct packed {
    logic [link_cfg_pkg::CREDIT_W-1:0] count;
  } credit_msg_t;

  ////////////////////////////////////////////////////////////
  // credit return state machine
  ////////////////////////////////////////////////////////////

  // in RET_COUNT the freed counter keeps growing and nothing is offered
  // in RET_OFFER the message is valid and its count stays frozen
  typedef enum logic {
    RET_COUNT = 1'b0,
    RET_OFFER = 1'b1
  } ret_state_e;

endpackage

`default_nettype wire

// File: rtl/link_cfg_pkg.sv
`default_nettype none

// sizing constants shared by every block of the credit channel
package link_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  // width of one data beat as it travels from source to sink
  localparam int DATA_W = 16;

  ////////////////////////////////////////////////////////////
  // credit accounting
  ////////////////////////////////////////////////////////////

  // credits held by the sender at reset, equal to the receive buffer depth
  localparam int NUM_CREDITS = 8;

  // freed credits that trigger a credit message without waiting for the buffer to empty
  // this value has to be at least 1, otherwise a zero count could be offered
  localparam int FORCE_SEND_THRESH = 4;

  // counter width covering 0 up to and including NUM_CREDITS
  localparam int CREDIT_W = $clog2(NUM_CREDITS + 1);

  // read and write pointer width of the receive buffer
  localparam int PTR_W = $clog2(NUM_CREDITS);

endpackage

`default_nettype wire
